// File: verilog/tlb_settings.svh
`ifndef TLB_SETTINGS_SVH
`define TLB_SETTINGS_SVH

// Virtual page number of a 32-bit address with 4 KiB pages.
`define TLB_VPN_WIDTH 20

// Set index comes from VPN bits 14 to 10.
`define TLB_IDX_WIDTH 5

// Stored tag is VPN[19:15] followed by VPN[9:0].
`define TLB_TAG_WIDTH 15

`define TLB_PTE_WIDTH 32  // PPN0 sits at bits 19 to 10.

`define TLB_DEPTH     32  // Sets per way.
`define TLB_WAY_NUM   4

`endif

// File: verilog/tlb_pkg.sv
`default_nettype none

`include "tlb_settings.svh"

package tlb_pkg;

    typedef logic [`TLB_VPN_WIDTH-1:0] vpn_t;

    // Low ten bits are zero for a superpage entry.
    typedef logic [`TLB_TAG_WIDTH-1:0] tag_t;

    typedef logic [`TLB_PTE_WIDTH-1:0] pte_t;

    typedef logic [`TLB_IDX_WIDTH-1:0] idx_t;

    // Highest rank is the most recently used way, zero is the victim.
    typedef logic [$clog2(`TLB_WAY_NUM)-1:0] rank_t;

    typedef logic [`TLB_WAY_NUM-1:0] way_mask_t;

endpackage

`default_nettype wire

// File: verilog/tlb_way_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_settings.svh"

module tlb_way_ram #(
    parameter type payload_t = tlb_pkg::pte_t
) (
    input  wire logic          clk,
    input  wire logic          cs,
    input  wire logic          we,
    input  wire tlb_pkg::idx_t addr,
    input  wire payload_t      wdata,
    output payload_t           rdata
);

    payload_t mem [`TLB_DEPTH];

    // Write port.
    always_ff @(posedge clk) begin
        if (cs && we) begin
            mem[addr] <= wdata;
        end
    end

    // Read data is registered and held while idle.
    always_ff @(posedge clk) begin
        if (cs && !we) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/tlb_lru_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_settings.svh"

module tlb_lru_ctrl (
    input  wire logic               clk,
    input  wire logic               rstn,
    input  wire logic               cs,
    input  wire logic               we,
    input  wire tlb_pkg::vpn_t      vpn,
    input  wire logic               spage,
    input  wire logic               tlb_flush_req,
    input  wire tlb_pkg::way_mask_t way_hit,
    output tlb_pkg::idx_t           set_idx,
    output tlb_pkg::way_mask_t      way_we,
    output tlb_pkg::way_mask_t      way_valid_q,
    output tlb_pkg::way_mask_t      way_spg_q
);

    import tlb_pkg::*;

    localparam rank_t RANK_MRU = rank_t'(`TLB_WAY_NUM - 1);

    way_mask_t valid_tab [`TLB_DEPTH];
    way_mask_t spg_tab   [`TLB_DEPTH];
    rank_t     rank_tab  [`TLB_DEPTH][`TLB_WAY_NUM];

    idx_t      idx_q;      // Set of the lookup now in its result cycle.
    logic      lookup;
    logic      fill;
    way_mask_t victim;
    logic      upd_en;
    idx_t      upd_idx;
    way_mask_t upd_mask;
    rank_t     upd_rank;   // Old rank of the way being promoted.

    function automatic logic ranks_distinct(input rank_t ranks [`TLB_WAY_NUM]);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < `TLB_WAY_NUM; i++) begin
            for (int j = i + 1; j < `TLB_WAY_NUM; j++) begin
                if (ranks[i] == ranks[j]) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    assign set_idx = vpn[10 +: `TLB_IDX_WIDTH];
    assign lookup  = cs && !we;
    assign fill    = cs && we && !tlb_flush_req;

    always_comb begin
        for (int k = 0; k < `TLB_WAY_NUM; k++) begin
            victim[k] = (rank_tab[set_idx][k] == '0);
        end
    end

    assign way_we = victim & {`TLB_WAY_NUM{fill}};

    // A fill owns the recency update; a hit in the same cycle is dropped.
    always_comb begin
        if (fill) begin
            upd_en   = 1'b1;
            upd_idx  = set_idx;
            upd_mask = victim;
        end else begin
            upd_en   = |way_hit;
            upd_idx  = idx_q;
            upd_mask = way_hit;
        end
        upd_rank = '0;
        for (int k = 0; k < `TLB_WAY_NUM; k++) begin
            upd_rank |= rank_tab[upd_idx][k] & {$bits(rank_t){upd_mask[k]}};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int d = 0; d < `TLB_DEPTH; d++) begin
                valid_tab[d] <= '0;
                spg_tab[d]   <= '0;
                for (int k = 0; k < `TLB_WAY_NUM; k++) begin
                    rank_tab[d][k] <= rank_t'(k);
                end
            end
        end else if (tlb_flush_req) begin
            for (int d = 0; d < `TLB_DEPTH; d++) begin
                valid_tab[d] <= '0;
                for (int k = 0; k < `TLB_WAY_NUM; k++) begin
                    rank_tab[d][k] <= rank_t'(k);
                end
            end
        end else if (upd_en) begin
            if (fill) begin
                valid_tab[set_idx] <= valid_tab[set_idx] | victim;
                spg_tab[set_idx]   <= (spg_tab[set_idx] & ~victim) |
                                      (victim & {`TLB_WAY_NUM{spage}});
            end
            for (int k = 0; k < `TLB_WAY_NUM; k++) begin
                if (upd_mask[k]) begin
                    rank_tab[upd_idx][k] <= RANK_MRU;
                end else if (rank_tab[upd_idx][k] > upd_rank) begin
                    rank_tab[upd_idx][k] <= rank_tab[upd_idx][k] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            idx_q       <= '0;
            way_valid_q <= '0;
            way_spg_q   <= '0;
        end else begin
            if (lookup) begin
                idx_q <= set_idx;
            end
            // Only a lookup may report a hit next cycle.
            way_valid_q <= (lookup && !tlb_flush_req) ? valid_tab[set_idx] : '0;
            way_spg_q   <= spg_tab[set_idx];
        end
    end

    a_fill_we_onehot: assert property (
        @(posedge clk) disable iff (!rstn)
        fill |-> $onehot(way_we)
    );

    a_hit_onehot0: assert property (
        @(posedge clk) disable iff (!rstn)
        $onehot0(way_hit)
    );

    a_ranks_distinct: assert property (
        @(posedge clk) disable iff (!rstn)
        upd_en |-> ranks_distinct(rank_tab[upd_idx])
    );

endmodule

`default_nettype wire

// File: verilog/tlb_way_match.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_settings.svh"

module tlb_way_match (
    input  wire logic                                 clk,
    input  wire logic                                 rstn,
    input  wire tlb_pkg::vpn_t                        vpn,
    input  wire logic                                 spage,
    input  wire tlb_pkg::way_mask_t                   way_valid_q,
    input  wire tlb_pkg::way_mask_t                   way_spg_q,
    input  wire tlb_pkg::tag_t [`TLB_WAY_NUM-1:0]     tag_rd,
    input  wire tlb_pkg::pte_t [`TLB_WAY_NUM-1:0]     pte_rd,
    output tlb_pkg::tag_t                             fill_tag,
    output tlb_pkg::way_mask_t                        way_hit,
    output logic                                      pte_hit,
    output tlb_pkg::pte_t                             pte_out
);

    import tlb_pkg::*;

    localparam int LO_W = 10;  // VPN bits covered by a superpage.

    tag_t tag_q;
    tag_t spg_tag_q;
    pte_t hit_pte;
    logic spg_hit;

    assign fill_tag = {vpn[`TLB_VPN_WIDTH-1:`TLB_IDX_WIDTH+LO_W],
                       vpn[LO_W-1:0] & {LO_W{~spage}}};

    // Low bits of the latched tag are the looked-up VPN[9:0].
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tag_q <= '0;
        end else begin
            tag_q <= {vpn[`TLB_VPN_WIDTH-1:`TLB_IDX_WIDTH+LO_W], vpn[LO_W-1:0]};
        end
    end

    assign spg_tag_q = {tag_q[`TLB_TAG_WIDTH-1:LO_W], {LO_W{1'b0}}};

    always_comb begin
        for (int k = 0; k < `TLB_WAY_NUM; k++) begin
            way_hit[k] = way_valid_q[k] &&
                         (tag_rd[k] == (way_spg_q[k] ? spg_tag_q : tag_q));
        end
    end

    always_comb begin
        hit_pte = '0;
        for (int k = 0; k < `TLB_WAY_NUM; k++) begin
            hit_pte |= pte_rd[k] & {`TLB_PTE_WIDTH{way_hit[k]}};
        end
    end

    assign spg_hit = |(way_hit & way_spg_q);
    assign pte_hit = |way_hit;

    // Superpage offset goes into PPN0.
    always_comb begin
        pte_out = hit_pte;
        if (spg_hit) begin
            pte_out[LO_W +: LO_W] = tag_q[LO_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: verilog/tlb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_settings.svh"

module tlb_top (
    input  wire logic          clk,
    input  wire logic          rstn,
    input  wire logic          cs,
    input  wire logic          we,
    input  wire tlb_pkg::vpn_t vpn,
    input  wire logic          spage,
    input  wire tlb_pkg::pte_t pte_in,
    input  wire logic          tlb_flush_req,
    output logic               pte_hit,
    output tlb_pkg::pte_t      pte_out
);

    import tlb_pkg::*;

    idx_t                         set_idx;
    way_mask_t                    way_we;
    way_mask_t                    way_valid_q;
    way_mask_t                    way_spg_q;
    way_mask_t                    way_hit;
    tag_t                         fill_tag;
    tag_t [`TLB_WAY_NUM-1:0]      tag_rd;
    pte_t [`TLB_WAY_NUM-1:0]      pte_rd;

    tlb_lru_ctrl u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .cs            (cs),
        .we            (we),
        .vpn           (vpn),
        .spage         (spage),
        .tlb_flush_req (tlb_flush_req),
        .way_hit       (way_hit),
        .set_idx       (set_idx),
        .way_we        (way_we),
        .way_valid_q   (way_valid_q),
        .way_spg_q     (way_spg_q)
    );

    tlb_way_match u_match (
        .clk         (clk),
        .rstn        (rstn),
        .vpn         (vpn),
        .spage       (spage),
        .way_valid_q (way_valid_q),
        .way_spg_q   (way_spg_q),
        .tag_rd      (tag_rd),
        .pte_rd      (pte_rd),
        .fill_tag    (fill_tag),
        .way_hit     (way_hit),
        .pte_hit     (pte_hit),
        .pte_out     (pte_out)
    );

    for (genvar g = 0; g < `TLB_WAY_NUM; g++) begin : g_way
        tlb_way_ram #(.payload_t(tag_t)) u_tag_ram (
            .clk   (clk),
            .cs    (cs),
            .we    (way_we[g]),
            .addr  (set_idx),
            .wdata (fill_tag),
            .rdata (tag_rd[g])
        );

        tlb_way_ram #(.payload_t(pte_t)) u_pte_ram (
            .clk   (clk),
            .cs    (cs),
            .we    (way_we[g]),
            .addr  (set_idx),
            .wdata (pte_in),
            .rdata (pte_rd[g])
        );
    end

endmodule

`default_nettype wire

// File: test/tlb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_checker #(
    parameter int NAME_CHARS = 24
) (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    cs,
    input  wire logic                    we,
    input  wire logic                    pte_hit,
    input  wire tlb_pkg::pte_t           pte_out,
    input  wire logic                    exp_hit,
    input  wire tlb_pkg::pte_t           exp_pte,
    input  wire logic [8*NAME_CHARS-1:0] test_name,
    output int                           check_count,
    output int                           error_count,
    output logic                         busy
);

    import tlb_pkg::*;

    logic                    pend;      // A lookup is in its result cycle.
    logic                    pend_hit;
    pte_t                    pend_pte;
    logic [8*NAME_CHARS-1:0] pend_name;

    assign busy = pend;

    // Inputs move on the rising edge, so the falling edge sees settled values.
    always @(negedge clk or negedge rstn) begin : compare
        int errs;
        errs = 0;
        if (!rstn) begin
            pend        <= 1'b0;
            pend_hit    <= 1'b0;
            pend_pte    <= '0;
            pend_name   <= '0;
            check_count <= 0;
            error_count <= 0;
        end else begin
            if (pend) begin
                if (pte_hit !== pend_hit) begin
                    $display("[ERROR] %0s: pte_hit expected %0b, actual %0b",
                             pend_name, pend_hit, pte_hit);
                    errs++;
                end
                if (pte_out !== pend_pte) begin
                    $display("[ERROR] %0s: pte_out expected %08h, actual %08h",
                             pend_name, pend_pte, pte_out);
                    errs++;
                end
                check_count <= check_count + 1;
                error_count <= error_count + errs;
            end
            // The DUT samples these at the next rising edge.
            pend      <= cs && !we;
            pend_hit  <= exp_hit;
            pend_pte  <= exp_pte;
            pend_name <= test_name;
        end
    end

endmodule

`default_nettype wire

// File: test/tlb_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_settings.svh"

module tlb_tb;

    import tlb_pkg::*;

    localparam int NAME_CHARS = 24;
    localparam int LINE_CHARS = 128;
    localparam int MAX_LINES  = 1000;
    localparam int RESET_WAIT = 20;
    localparam int DRAIN_WAIT = 10;

    logic                    clk;
    logic                    rstn;
    logic                    cs;
    logic                    we;
    vpn_t                    vpn;
    logic                    spage;
    pte_t                    pte_in;
    logic                    tlb_flush_req;
    logic                    pte_hit;
    pte_t                    pte_out;

    logic                    exp_hit;
    pte_t                    exp_pte;
    logic [8*NAME_CHARS-1:0] test_name;
    int                      check_count;
    int                      error_count;
    int                      other_errors;
    logic                    chk_busy;

    tlb_top uut (
        .clk           (clk),
        .rstn          (rstn),
        .cs            (cs),
        .we            (we),
        .vpn           (vpn),
        .spage         (spage),
        .pte_in        (pte_in),
        .tlb_flush_req (tlb_flush_req),
        .pte_hit       (pte_hit),
        .pte_out       (pte_out)
    );

    tlb_checker #(.NAME_CHARS(NAME_CHARS)) u_checker (
        .clk         (clk),
        .rstn        (rstn),
        .cs          (cs),
        .we          (we),
        .pte_hit     (pte_hit),
        .pte_out     (pte_out),
        .exp_hit     (exp_hit),
        .exp_pte     (exp_pte),
        .test_name   (test_name),
        .check_count (check_count),
        .error_count (error_count),
        .busy        (chk_busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
    end

    task automatic drive_idle();
        cs            <= 1'b0;
        we            <= 1'b0;
        tlb_flush_req <= 1'b0;
        exp_hit       <= 1'b0;
        exp_pte       <= '0;
    endtask

    // A flush row also carries a lookup, which must miss.
    task automatic drive_row(input logic [63:0] op, input logic [31:0] v,
                             input logic [31:0] s, input logic [31:0] p,
                             input logic [31:0] eh, input logic [31:0] ep,
                             input logic [8*NAME_CHARS-1:0] nm);
        cs            <= 1'b1;
        we            <= (op == "fill");
        tlb_flush_req <= (op == "flush");
        vpn           <= v[`TLB_VPN_WIDTH-1:0];
        spage         <= s[0];
        pte_in        <= p;
        exp_hit       <= eh[0];
        exp_pte       <= ep;
        test_name     <= nm;
    endtask

    initial begin : stimulus
        int                      fd;
        int                      lines;
        int                      waits;
        int                      n;
        logic [8*LINE_CHARS-1:0] line_buf;
        logic [7:0]              first_ch;
        logic [8*NAME_CHARS-1:0] name_v;
        logic [63:0]             op_v;
        logic [31:0]             vpn_v;
        logic [31:0]             spg_v;
        logic [31:0]             pte_v;
        logic [31:0]             hit_v;
        logic [31:0]             exp_v;
        other_errors  = 0;
        cs            = 1'b0;
        we            = 1'b0;
        vpn           = '0;
        spage         = 1'b0;
        pte_in        = '0;
        tlb_flush_req = 1'b0;
        exp_hit       = 1'b0;
        exp_pte       = '0;
        test_name     = '0;

        waits = 0;
        while (rstn !== 1'b1 && waits < RESET_WAIT) begin
            @(posedge clk);
            waits++;
        end
        if (rstn !== 1'b1) begin
            $display("Reset did not release within %0d cycles", RESET_WAIT);
            other_errors++;
        end

        fd = $fopen("test/tlb_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/tlb_testdata.txt");
            other_errors++;
        end else begin
            lines = 0;
            while (!$feof(fd) && lines < MAX_LINES) begin
                line_buf = '0;
                n = $fgets(line_buf, fd);
                lines++;
                if (n > 0 && $sscanf(line_buf, " %c", first_ch) == 1 && first_ch != "#") begin
                    n = $sscanf(line_buf, "%s %s %h %h %h %h %h",
                                name_v, op_v, vpn_v, spg_v, pte_v, hit_v, exp_v);
                    if (n != 7 || !(op_v == "fill" || op_v == "lookup" || op_v == "flush")) begin
                        $display("Data line %0d could not be parsed", lines);
                        other_errors++;
                    end else begin
                        @(posedge clk);
                        drive_row(op_v, vpn_v, spg_v, pte_v, hit_v, exp_v, name_v);
                    end
                end
            end
            if (!$feof(fd)) begin
                $display("Data file did not end within %0d lines", MAX_LINES);
                other_errors++;
            end
            $fclose(fd);
        end

        @(posedge clk);
        drive_idle();
        waits = 0;
        while ((waits < 2 || chk_busy) && waits < DRAIN_WAIT) begin
            @(posedge clk);
            waits++;
        end
        if (chk_busy) begin
            $display("Last lookup was not checked within %0d cycles", DRAIN_WAIT);
            other_errors++;
        end

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, error_count, other_errors);
        if (error_count == 0 && other_errors == 0 && check_count > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tlb.f
+incdir+verilog
verilog/tlb_pkg.sv
verilog/tlb_way_ram.sv
verilog/tlb_lru_ctrl.sv
verilog/tlb_way_match.sv
verilog/tlb_top.sv
test/tlb_checker.sv
test/tlb_tb.sv

// File: test/tlb_testdata.txt
# Columns: name op vpn spage pte_in exp_hit exp_pte, numbers in hex, one row per cycle.
# A flush row also looks up its vpn; exp columns of fill rows are ignored.
reset_miss   lookup 00000 0 00000000 0 00000000
reset_miss   lookup 12345 0 00000000 0 00000000
reset_miss   lookup fffff 0 00000000 0 00000000
page_fill    fill   08855 0 a5a51234 0 00000000
page_hit     lookup 08855 0 00000000 1 a5a51234
page_tag_hi  lookup 18855 0 00000000 0 00000000
page_tag_lo  lookup 08856 0 00000000 0 00000000
page_set     lookup 08c55 0 00000000 0 00000000
spg_fill     fill   11400 1 3c0ffc0f 0 00000000
spg_base     lookup 11400 0 00000000 1 3c00000f
spg_off      lookup 11523 0 00000000 1 3c048c0f
spg_top      lookup 117ff 0 00000000 1 3c0ffc0f
spg_tag_hi   lookup 19400 0 00000000 0 00000000
evict_fill   fill   01c01 0 000a1001 0 00000000
evict_fill   fill   09c01 0 000b1002 0 00000000
evict_fill   fill   11c01 0 000c1003 0 00000000
evict_fill   fill   19c01 0 000d1004 0 00000000
evict_fill   fill   21c01 0 000e1005 0 00000000
evict_old    lookup 01c01 0 00000000 0 00000000
evict_keep   lookup 09c01 0 00000000 1 000b1002
evict_keep   lookup 11c01 0 00000000 1 000c1003
evict_keep   lookup 19c01 0 00000000 1 000d1004
evict_keep   lookup 21c01 0 00000000 1 000e1005
mru_fill     fill   02402 0 00f20001 0 00000000
mru_fill     fill   0a402 0 00f20002 0 00000000
mru_fill     fill   12402 0 00f20003 0 00000000
mru_fill     fill   1a402 0 00f20004 0 00000000
mru_touch    lookup 02402 0 00000000 1 00f20001
mru_gap      lookup 00000 0 00000000 0 00000000
mru_fill     fill   22402 0 00f20005 0 00000000
mru_evict    lookup 0a402 0 00000000 0 00000000
mru_keep     lookup 02402 0 00000000 1 00f20001
mru_keep     lookup 12402 0 00000000 1 00f20003
mru_keep     lookup 1a402 0 00000000 1 00f20004
mru_keep     lookup 22402 0 00000000 1 00f20005
flush_same   flush  21c01 0 00000000 0 00000000
flush_miss   lookup 08855 0 00000000 0 00000000
flush_miss   lookup 11523 0 00000000 0 00000000
flush_miss   lookup 19c01 0 00000000 0 00000000
flush_miss   lookup 1a402 0 00000000 0 00000000
refill       fill   08855 0 5a5a0001 0 00000000
b2b_hit      lookup 08855 0 00000000 1 5a5a0001
b2b_miss     lookup 18855 0 00000000 0 00000000
b2b_hit      lookup 08855 0 00000000 1 5a5a0001
